//--- logic/cache_pkg.sv
// Package with the hierarchy widths, sizes, vector types, request and lookup structs, FSM states
`default_nettype none

package cache_pkg;

  // Address split is 5 tag bits over 1 L1 set index bit
  localparam int ADDR_W    = 6;
  localparam int DATA_W    = 16;
  localparam int L1_SETS   = 2;
  localparam int L1_WAYS   = 2;
  localparam int L1_TAG_W  = 5;  // Address bits above the set index
  localparam int L2_LINES  = 8;
  localparam int AGE_W     = 3;  // One age counter per L2 line
  localparam int MEM_WORDS = 64;
  localparam int MEM_LAT   = 2;  // Read latency of main memory in cycles

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [L1_TAG_W-1:0] l1_tag_t;
  typedef logic [AGE_W-1:0]    age_t;

  localparam age_t AGE_MAX = age_t'(2**AGE_W - 1); // Oldest age, also the L2 victim mark

  // Update request into a cache, fill or write
  typedef struct packed {
    logic  en;
    addr_t addr;
    word_t data;
  } cache_req_t;

  // Combinational lookup result
  typedef struct packed {
    logic  hit;
    word_t data;
  } lookup_t;

  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t data;
  } mem_req_t;

  typedef enum logic [1:0] {IDLE, L2_STEP, MEM_WAIT} ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/main_memory.sv
// Main memory word array, cleared on reset, with single-cycle write and two-stage read
`default_nettype none

module main_memory (
  input  wire logic                i_clock,
  input  wire logic                i_reset,
  input  wire cache_pkg::mem_req_t i_req,
  output cache_pkg::word_t         o_rdata,
  output logic                     o_rvalid
);
  import cache_pkg::*;

  word_t              mem_q [MEM_WORDS];
  addr_t              raddr_q;   // Address stage
  word_t              rdata_q;   // Data stage
  logic [MEM_LAT-1:0] rvalid_q;  // One valid bit per read stage

  always_ff @(posedge i_clock or posedge i_reset)
  begin
    if (i_reset)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem_q[i] <= '0;
      rvalid_q <= '0;
    end
    else
    begin
      if (i_req.wr)
        mem_q[i_req.addr] <= i_req.data;
      rvalid_q <= {rvalid_q[MEM_LAT-2:0], i_req.rd};
    end
  end

  always_ff @(posedge i_clock)
  begin
    raddr_q <= i_req.addr;
    rdata_q <= mem_q[raddr_q];
  end

  assign o_rdata  = rdata_q;
  assign o_rvalid = rvalid_q[MEM_LAT-1];

  // Controller writes only in IDLE and reads only in L2_STEP
  a_no_rd_wr: assert property (@(posedge i_clock) disable iff (i_reset)
    !(i_req.rd && i_req.wr));

endmodule

`default_nettype wire

//--- logic/l1_set_assoc.sv
// L1 cache with 2-way set-associative arrays, tag compare, way choice and per-set LRU
`default_nettype none

module l1_set_assoc (
  input  wire logic                  i_clock,
  input  wire logic                  i_reset,
  input  wire cache_pkg::addr_t      i_addr,
  input  wire cache_pkg::cache_req_t i_req,
  output cache_pkg::lookup_t         o_look
);
  import cache_pkg::*;

  word_t   data_q [L1_SETS][L1_WAYS];
  l1_tag_t tag_q  [L1_SETS][L1_WAYS];
  logic [L1_SETS-1:0][L1_WAYS-1:0] valid_q;
  logic [L1_SETS-1:0]              lru_q;  // Way to replace next in each set

  logic [$clog2(L1_SETS)-1:0] look_set;
  logic [$clog2(L1_SETS)-1:0] upd_set;
  logic [L1_WAYS-1:0]         look_hit;
  logic [L1_WAYS-1:0]         upd_hit;
  logic                       upd_way;  // Way written by a request

  // Both ways of the set holding this address compared
  function automatic logic [L1_WAYS-1:0] way_match(addr_t a);
    logic [L1_WAYS-1:0] m;
    for (int w = 0; w < L1_WAYS; w++)
      m[w] = valid_q[a[ADDR_W-L1_TAG_W-1:0]][w] &&
             (tag_q[a[ADDR_W-L1_TAG_W-1:0]][w] == a[ADDR_W-1 -: L1_TAG_W]);
    return m;
  endfunction

  assign look_set = i_addr[ADDR_W-L1_TAG_W-1:0];
  assign upd_set  = i_req.addr[ADDR_W-L1_TAG_W-1:0];

  always_comb
  begin
    look_hit    = way_match(i_addr);
    o_look.hit  = |look_hit;
    o_look.data = '0;
    for (int w = 0; w < L1_WAYS; w++)
      if (look_hit[w])
        o_look.data = data_q[look_set][w];
  end

  // Victim order is hit way, invalid way 0, invalid way 1, then LRU
  always_comb
  begin
    upd_hit = way_match(i_req.addr);
    if (|upd_hit)
      upd_way = upd_hit[1];
    else if (!valid_q[upd_set][0])
      upd_way = 1'b0;
    else if (!valid_q[upd_set][1])
      upd_way = 1'b1;
    else
      upd_way = lru_q[upd_set];
  end

  always_ff @(posedge i_clock or posedge i_reset)
  begin
    if (i_reset)
    begin
      valid_q <= '0;
      lru_q   <= '0;
    end
    else if (i_req.en)
    begin
      valid_q[upd_set][upd_way] <= 1'b1;
      lru_q[upd_set]            <= ~upd_way; // Other way becomes LRU
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_req.en)
    begin
      data_q[upd_set][upd_way] <= i_req.data;
      tag_q[upd_set][upd_way]  <= i_req.addr[ADDR_W-1 -: L1_TAG_W];
    end
  end

  for (genvar s = 0; s < L1_SETS; s++)
  begin : g_set_chk
    // A fill only happens on a miss, so a tag never lands twice in one set
    a_no_dup_tag: assert property (@(posedge i_clock) disable iff (i_reset)
      !(valid_q[s][0] && valid_q[s][1] && (tag_q[s][0] == tag_q[s][1])));
  end

endmodule

`default_nettype wire

//--- logic/l2_fully_assoc.sv
// L2 cache with fully associative lines, parallel compare, victim choice and age counters
`default_nettype none

module l2_fully_assoc (
  input  wire logic                  i_clock,
  input  wire logic                  i_reset,
  input  wire cache_pkg::addr_t      i_addr,
  input  wire cache_pkg::cache_req_t i_req,
  output cache_pkg::lookup_t         o_look
);
  import cache_pkg::*;

  word_t                 data_q [L2_LINES];
  addr_t                 tag_q  [L2_LINES];  // Full address as tag
  age_t                  age_q  [L2_LINES];
  logic [L2_LINES-1:0]   valid_q;

  logic [L2_LINES-1:0]         look_hit;
  logic [L2_LINES-1:0]         upd_hit;
  logic [$clog2(L2_LINES)-1:0] upd_line;  // Line touched or allocated
  age_t                        old_age;   // Age of that line before the touch
  logic                        found;

  function automatic logic [L2_LINES-1:0] line_match(addr_t a);
    logic [L2_LINES-1:0] m;
    for (int k = 0; k < L2_LINES; k++)
      m[k] = valid_q[k] && (tag_q[k] == a);
    return m;
  endfunction

  always_comb
  begin
    look_hit    = line_match(i_addr);
    o_look.hit  = |look_hit;
    o_look.data = '0;
    for (int k = 0; k < L2_LINES; k++)
      if (look_hit[k])
        o_look.data = data_q[k];
  end

  // Matching line first, then first invalid, then the oldest
  always_comb
  begin
    upd_hit  = line_match(i_req.addr);
    upd_line = '0;
    old_age  = AGE_MAX;  // New allocation counts as oldest
    found    = 1'b0;
    for (int k = 0; k < L2_LINES; k++)
      if (!found && upd_hit[k])
      begin
        upd_line = k[$clog2(L2_LINES)-1:0];
        old_age  = age_q[k];
        found    = 1'b1;
      end
    for (int k = 0; k < L2_LINES; k++)
      if (!found && !valid_q[k])
      begin
        upd_line = k[$clog2(L2_LINES)-1:0];
        found    = 1'b1;
      end
    for (int k = 0; k < L2_LINES; k++)
      if (!found && (age_q[k] == AGE_MAX))
      begin
        upd_line = k[$clog2(L2_LINES)-1:0];
        found    = 1'b1;
      end
  end

  always_ff @(posedge i_clock or posedge i_reset)
  begin
    if (i_reset)
    begin
      valid_q <= '0;
      for (int k = 0; k < L2_LINES; k++)
        age_q[k] <= '0;
    end
    else if (i_req.en)
    begin
      valid_q[upd_line] <= 1'b1;
      for (int k = 0; k < L2_LINES; k++)
        if (k == upd_line)
          age_q[k] <= '0;                   // Most recent
        else if (valid_q[k] && (age_q[k] < old_age))
          age_q[k] <= age_q[k] + 1'b1;      // Younger lines slide back, saturates at AGE_MAX
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_req.en)
    begin
      data_q[upd_line] <= i_req.data;
      tag_q[upd_line]  <= i_req.addr;
    end
  end

  // Allocation only on miss keeps every address in at most one line
  a_single_match: assert property (@(posedge i_clock) disable iff (i_reset)
    $onehot0(look_hit));

endmodule

`default_nettype wire

//--- logic/mem_hier_ctrl.sv
// APB slave and sequencing FSM for L1 hits, L2 hits, memory reads and write-through
`default_nettype none

module mem_hier_ctrl (
  input  wire logic                 i_clock,
  input  wire logic                 i_reset,
  input  wire logic                 i_psel,
  input  wire logic                 i_penable,
  input  wire logic                 i_pwrite,
  input  wire cache_pkg::addr_t     i_paddr,
  input  wire cache_pkg::word_t     i_pwdata,
  input  wire cache_pkg::lookup_t   i_l1_look,
  input  wire cache_pkg::lookup_t   i_l2_look,
  input  wire cache_pkg::word_t     i_mem_rdata,
  input  wire logic                 i_mem_rvalid,
  output cache_pkg::cache_req_t     o_l1_req,
  output cache_pkg::cache_req_t     o_l2_req,
  output cache_pkg::mem_req_t       o_mem_req,
  output logic                      o_pready,
  output cache_pkg::word_t          o_prdata,
  output logic                      o_hit_l1,
  output logic                      o_hit_l2
);
  import cache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        access;  // APB access phase

  assign access = i_psel & i_penable;

  always_ff @(posedge i_clock or posedge i_reset)
  begin
    if (i_reset)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d   = state_q;
    o_pready  = 1'b0;
    o_prdata  = i_l1_look.data;
    o_hit_l1  = 1'b0;
    o_hit_l2  = 1'b0;
    o_l1_req  = '{en: 1'b0, addr: i_paddr, data: i_pwdata}; // Address always the APB one
    o_l2_req  = '{en: 1'b0, addr: i_paddr, data: i_pwdata};
    o_mem_req = '{rd: 1'b0, wr: 1'b0, addr: i_paddr, data: i_pwdata};
    case (state_q)
      IDLE:
      begin
        if (access && i_pwrite)
        begin
          // Write-through into all three levels in one cycle
          o_pready      = 1'b1;
          o_prdata      = i_pwdata;       // Written word echoed back
          o_hit_l1      = i_l1_look.hit;  // Flags from before the update
          o_hit_l2      = i_l2_look.hit;
          o_l1_req.en   = 1'b1;
          o_l2_req.en   = 1'b1;
          o_mem_req.wr  = 1'b1;
        end
        else if (access && i_l1_look.hit)
        begin
          o_pready = 1'b1; // L1 read hit, L2 left alone
          o_hit_l1 = 1'b1;
        end
        else if (access)
          state_d = L2_STEP;
      end
      L2_STEP:
      begin
        if (i_l2_look.hit)
        begin
          o_pready      = 1'b1;
          o_prdata      = i_l2_look.data;
          o_hit_l2      = 1'b1;
          o_l1_req.en   = 1'b1;            // Fill L1 from L2
          o_l1_req.data = i_l2_look.data;
          state_d       = IDLE;
        end
        else
        begin
          o_mem_req.rd = 1'b1; // Memory read issued at the end of this cycle
          state_d      = MEM_WAIT;
        end
      end
      MEM_WAIT:
      begin
        if (i_mem_rvalid)
        begin
          o_pready      = 1'b1;
          o_prdata      = i_mem_rdata;
          o_l1_req.en   = 1'b1;  // Fill both caches
          o_l1_req.data = i_mem_rdata;
          o_l2_req.en   = 1'b1;
          o_l2_req.data = i_mem_rdata;
          state_d       = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Master must keep the transfer open while the FSM is busy with it
  a_pready_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
    o_pready |-> (i_psel && i_penable));

endmodule

`default_nettype wire

//--- logic/mem_hier_top.sv
// Top level of the memory hierarchy with APB slave, L1, L2 and main memory
`default_nettype none

module mem_hier_top (
  input  wire logic           i_clock,
  input  wire logic           i_reset,
  input  wire logic           i_psel,
  input  wire logic           i_penable,
  input  wire logic           i_pwrite,
  input  wire cache_pkg::addr_t i_paddr,
  input  wire cache_pkg::word_t i_pwdata,
  output logic                o_pready,
  output logic                o_hit_l1,
  output logic                o_hit_l2,
  output cache_pkg::word_t    o_prdata
);
  import cache_pkg::*;

  cache_req_t l1_req;  // Fill or write into L1
  cache_req_t l2_req;
  lookup_t    l1_look; // Lookups on the APB address
  lookup_t    l2_look;
  mem_req_t   mem_req;
  word_t      mem_rdata;
  logic       mem_rvalid;

  mem_hier_ctrl u_ctrl (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_l1_look    (l1_look),
    .i_l2_look    (l2_look),
    .i_mem_rdata  (mem_rdata),
    .i_mem_rvalid (mem_rvalid),
    .o_l1_req     (l1_req),
    .o_l2_req     (l2_req),
    .o_mem_req    (mem_req),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_hit_l1     (o_hit_l1),
    .o_hit_l2     (o_hit_l2)
  );

  l1_set_assoc u_l1 (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_addr  (i_paddr),
    .i_req   (l1_req),
    .o_look  (l1_look)
  );

  l2_fully_assoc u_l2 (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_addr  (i_paddr),
    .i_req   (l2_req),
    .o_look  (l2_look)
  );

  main_memory u_mem (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_req    (mem_req),
    .o_rdata  (mem_rdata),
    .o_rvalid (mem_rvalid)
  );

endmodule

`default_nettype wire

//--- verif/tb_mem_hier.sv
// Testbench for the memory hierarchy with clock, reset, APB driver, vector reader, checks, timeout
`default_nettype none

module tb_mem_hier;
  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  localparam int          HALF_PERIOD  = 10;  // 20 ns clock
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] SEED         = 32'h27b2_a9d1;
  localparam string       VEC_FILE     = "verif/mem_hier_vectors.txt";

  // One transfer from the vector file
  typedef struct packed {
    logic  wr;
    addr_t addr;
    word_t data;    // Write data, or expected read data
    logic  hit_l1;
    logic  hit_l2;
  } vector_t;

  logic  clock;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  logic  pready;
  logic  hit_l1;
  logic  hit_l2;
  word_t prdata;

  vector_t vectors[$];
  int      error_count   = 0;
  int      check_count   = 0;
  int      cycle_count   = 0;
  int      timeout_limit = 0;  // Set once the vectors are loaded

  mem_hier_top u_dut (
    .i_clock   (clock),
    .i_reset   (reset),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_pready  (pready),
    .o_hit_l1  (hit_l1),
    .o_hit_l2  (hit_l2),
    .o_prdata  (prdata)
  );

  initial
  begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // Stops a stalled run
  always @(posedge clock)
  begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count > timeout_limit)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  // o_pready watched in every cycle, sampled in the middle of the low phase
  initial
  begin
    forever
    begin
      @(negedge clock);
      #(HALF_PERIOD / 2);
      if (!reset)
        check_value(32'(pready && !(psel && penable)), 32'd0, "o_pready outside access phase");
    end
  end

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] h1;
    logic [31:0] h2;
    vector_t     v;
    ok = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %h %h %d %d", op, a, d, h1, h2);
        if (n == 5 && (op == "R" || op == "W"))  // Comment and blank lines skipped
        begin
          v.wr     = (op == "W");
          v.addr   = addr_t'(a);
          v.data   = word_t'(d);
          v.hit_l1 = h1[0];
          v.hit_l2 = h2[0];
          vectors.push_back(v);
        end
      end
      $fclose(fd);
      ok = (vectors.size() > 0);
    end
  endtask

  // Access cycles up to o_pready, by transfer kind
  function automatic int expected_cycles(vector_t v);
    if (v.wr || v.hit_l1)
      return 1;
    else if (v.hit_l2)
      return 2;
    else
      return 2 + MEM_LAT;  // L1 and L2 steps, then the memory read
  endfunction

  // Starts at a falling edge, ends at the falling edge after completion
  task automatic apb_transfer(input vector_t v, input int idx);
    int    cycles;
    logic  ready;
    word_t rdata;
    logic  h1;
    logic  h2;
    string tag;
    tag     = $sformatf("vector %0d %s 0x%0h", idx, v.wr ? "W" : "R", v.addr);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = v.wr;
    paddr   = v.addr;
    pwdata  = v.wr ? v.data : '0;
    @(negedge clock);
    penable = 1'b1;
    cycles  = 0;
    ready   = 1'b0;
    while (!ready)
    begin
      if (cycles > 0)
        @(negedge clock);
      #(HALF_PERIOD / 2);
      cycles++;
      ready = pready;
      rdata = prdata;
      h1    = hit_l1;
      h2    = hit_l2;
    end
    check_value(cycles, expected_cycles(v), {tag, " access cycles"});
    check_value(h1, v.hit_l1, {tag, " o_hit_l1"});
    check_value(h2, v.hit_l2, {tag, " o_hit_l2"});
    if (!v.wr)
      check_value(rdata, v.data, {tag, " o_prdata"});
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial
  begin
    bit loaded;
    int gap;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(SEED));
    load_vectors(loaded);
    if (!loaded)
    begin
      $display("Error: no vectors could be read from %s", VEC_FILE);
      $display("Simulation FAILED");
      $finish;
    end
    else
    begin
      timeout_limit = vectors.size() * 8 + RESET_CYCLES + 50;
      repeat (RESET_CYCLES) @(negedge clock);
      reset = 1'b0;
      for (int i = 0; i < vectors.size(); i++)
      begin
        gap = $urandom_range(3, 0);  // Idle cycles before the setup phase
        repeat (gap) @(negedge clock);
        apb_transfer(vectors[i], i);
      end
      $display("Done: %0d vectors, %0d checks, %0d errors",
               vectors.size(), check_count, error_count);
      if (error_count == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/mem_hier_vectors.txt
# op addr(hex) data(hex, write data or expected read data) hit_l1 hit_l2
# R read, W write; hit flags are those expected with o_pready
R 03 0000 0 0
W 04 1111 0 0
R 04 1111 1 0
W 06 2222 0 0
W 08 3333 0 0
R 04 1111 0 1
R 04 1111 1 0
R 06 2222 0 1
W 04 4444 1 1
R 04 4444 1 0
W 21 5501 0 0
W 23 5502 0 0
W 25 5503 0 0
W 27 5504 0 0
W 29 5505 0 0
W 2B 5506 0 0
W 0A 6601 0 0
R 06 2222 0 0
R 06 2222 1 0
R 08 3333 0 0
R 04 4444 0 0
R 0A 6601 0 1
R 0A 6601 1 0
W 0A 6602 1 1
R 0A 6602 1 0
R 29 5505 1 0
R 21 5501 0 0
R 29 5505 0 1
R 2B 5506 0 1
R 3E 0000 0 0

//--- files.f
logic/cache_pkg.sv
logic/main_memory.sv
logic/l1_set_assoc.sv
logic/l2_fully_assoc.sv
logic/mem_hier_ctrl.sv
logic/mem_hier_top.sv
verif/tb_mem_hier.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mem_hier
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
